// ==== calc_top.f ====
+incdir+hdl
hdl/gencon_pkg.sv
hdl/key_buffer.sv
hdl/addsub_unit.sv
hdl/shift_add_mult.sv
hdl/gencon.sv
hdl/calc_top.sv
tests/tb_clock.sv
tests/calc_tb.sv

// ==== tests/calc_tb.sv ====
// Fixed-seed random key streams checked against a calculator model; keys are sent one at a time
`timescale 1ns/1ns
`include "gencon_cfg.svh"

module calc_tb;

    localparam int MAG_MOD      = 1 << (`GENCON_WIDTH - 1);
    localparam int KEY_TIMEOUT  = 100;
    localparam int DONE_TIMEOUT = 200;

    logic                   clk;
    logic                   nRST;
    logic                   key_valid;
    gencon_pkg::key_event_t key_in;
    logic                   key_ready;
    logic                   complete;
    gencon_pkg::operand_t   display;

    logic [15:0]            lfsr;
    int                     errors;
    int                     checks;
    int                     pulses;
    int                     last_stall;
    // Calculator model
    gencon_pkg::operand_t   m_op1;
    gencon_pkg::operand_t   m_op2;
    gencon_pkg::op_t        m_oper;
    logic                   m_second;
    gencon_pkg::operand_t   m_result;
    int                     m_pulses;

    tb_clock u_clock (.clk(clk), .nRST(nRST));

    calc_top u_dut (
        .clk       (clk),
        .nRST      (nRST),
        .key_valid (key_valid),
        .key_in    (key_in),
        .key_ready (key_ready),
        .complete  (complete),
        .display   (display)
    );

    always @(negedge clk) begin
        if (nRST && complete === 1'b1) begin
            pulses++;
        end
    end

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic get_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    task automatic pick_op(output gencon_pkg::op_t op);
        int r;
        get_bits(2, r);
        case (r % 3)
            0: op = gencon_pkg::ADD;
            1: op = gencon_pkg::SUB;
            default: op = gencon_pkg::MUL;
        endcase
    endtask

    task automatic print_counts();
        $display("Checks: %0d  Errors: %0d  Complete pulses: %0d", checks, errors, pulses);
    endtask

    task automatic abort_run(input string what);
        gencon_pkg::state_t st;
        st = u_dut.u_gencon.state;
        $display("%0t ns: %s, gencon in state %s", $time, what, st.name());
        print_counts();
        $display("Testbench failed");
        $finish;
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Signed value to wrapped sign-magnitude with a positive zero
    function automatic gencon_pkg::operand_t to_operand(input int v);
        gencon_pkg::operand_t r;
        r.mag  = (v < 0 ? -v : v) % MAG_MOD;
        r.sign = (v < 0) && (r.mag != 0);
        return r;
    endfunction

    task automatic model_key(input gencon_pkg::key_event_t k);
        int va;
        int vb;
        int m;
        case (k.kind)
            gencon_pkg::DIGIT: begin
                if (m_second) m_op2.mag = (m_op2.mag * `GENCON_BASE + k.digit) % MAG_MOD;
                else m_op1.mag = (m_op1.mag * `GENCON_BASE + k.digit) % MAG_MOD;
            end
            gencon_pkg::OPER: begin
                if (k.oper == gencon_pkg::NEG && m_second) m_op2.sign = ~m_op2.sign;
                else if (k.oper == gencon_pkg::NEG) m_op1.sign = ~m_op1.sign;
                else if (!m_second) begin
                    m_oper   = k.oper;
                    m_second = 1'b1;
                end
            end
            default: begin
                // EQUAL counts only once an operator is latched
                if (m_second) begin
                    va = m_op1.sign ? -int'(m_op1.mag) : int'(m_op1.mag);
                    vb = m_op2.sign ? -int'(m_op2.mag) : int'(m_op2.mag);
                    m  = (int'(m_op1.mag) * int'(m_op2.mag)) % MAG_MOD;
                    if (m_oper == gencon_pkg::MUL) begin
                        m_result = to_operand((m_op1.sign ^ m_op2.sign) ? -m : m);
                    end else if (m_oper == gencon_pkg::SUB) begin
                        m_result = to_operand(va - vb);
                    end else begin
                        m_result = to_operand(va + vb);
                    end
                    m_pulses++;
                    m_op1    = '0;
                    m_op2    = '0;
                    m_oper   = gencon_pkg::NONE;
                    m_second = 1'b0;
                end
            end
        endcase
    endtask

    // Offer on the falling edge and hold until a rising edge with key_ready high
    task automatic send_key(input gencon_pkg::key_event_t k);
        int waited;
        waited = 0;
        @(negedge clk);
        key_in    = k;
        key_valid = 1'b1;
        while (key_ready !== 1'b1 && waited < KEY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (key_ready !== 1'b1) begin
            abort_run("key_ready stayed low");
        end else begin
            last_stall = waited;
            @(posedge clk);
        end
    endtask

    task automatic press(input gencon_pkg::key_kind_t kind, input int digit,
                         input gencon_pkg::op_t oper);
        gencon_pkg::key_event_t k;
        k.kind  = kind;
        k.digit = digit[3:0];
        k.oper  = oper;
        model_key(k);
        send_key(k);
    endtask

    // One to four digits with NEG keys before or between them
    task automatic enter_operand();
        int n;
        int r;
        get_bits(2, n);
        for (int i = 0; i <= n; i++) begin
            get_bits(2, r);
            if (r == 0) press(gencon_pkg::OPER, 0, gencon_pkg::NEG);
            get_bits(4, r);
            press(gencon_pkg::DIGIT, r % `GENCON_BASE, gencon_pkg::NONE);
        end
    endtask

    task automatic equal_and_check();
        int waited;
        press(gencon_pkg::EQUAL, 0, gencon_pkg::NONE);
        @(negedge clk);
        key_valid = 1'b0;
        waited    = 0;
        while (complete !== 1'b1 && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (complete !== 1'b1) begin
            abort_run("no complete pulse after EQUAL");
        end else begin
            check_value("display", display, m_result);
            @(negedge clk);
            check_value("complete pulse count", pulses, m_pulses);
        end
    endtask

    task automatic random_expression(input gencon_pkg::op_t op);
        enter_operand();
        press(gencon_pkg::OPER, 0, op);
        enter_operand();
        equal_and_check();
    endtask

    task automatic ignored_key_expression();
        gencon_pkg::op_t op;
        enter_operand();
        press(gencon_pkg::EQUAL, 0, gencon_pkg::NONE);
        enter_operand();
        pick_op(op);
        press(gencon_pkg::OPER, 0, op);
        enter_operand();
        pick_op(op);
        press(gencon_pkg::OPER, 0, op);
        enter_operand();
        equal_and_check();
    endtask

    initial begin
        int r;
        int n;
        errors     = 0;
        checks     = 0;
        pulses     = 0;
        last_stall = 0;
        lfsr       = 16'd84;
        m_op1      = '0;
        m_op2      = '0;
        m_oper     = gencon_pkg::NONE;
        m_second   = 1'b0;
        m_result   = '0;
        m_pulses   = 0;
        key_valid  = 1'b0;
        key_in     = '0;

        n = 0;
        while (nRST !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (nRST !== 1'b1) begin
            abort_run("reset was never released");
        end else begin
            check_value("key_ready", key_ready, 1);
            check_value("display", display, 0);
            repeat (10) @(negedge clk);
            check_value("complete pulse count", pulses, 0);

            repeat (40) begin
                get_bits(1, r);
                if (r != 0) random_expression(gencon_pkg::SUB);
                else random_expression(gencon_pkg::ADD);
            end
            repeat (30) random_expression(gencon_pkg::MUL);
            repeat (6) ignored_key_expression();

            // Keys back to back while the digit multiply runs
            press(gencon_pkg::DIGIT, 1, gencon_pkg::NONE);
            press(gencon_pkg::DIGIT, 2, gencon_pkg::NONE);
            check_value("key_ready low for second key", last_stall > 0, 1);
            press(gencon_pkg::DIGIT, 3, gencon_pkg::NONE);
            check_value("key_ready low during multiply", last_stall > 10, 1);
            press(gencon_pkg::OPER, 0, gencon_pkg::ADD);
            press(gencon_pkg::DIGIT, 4, gencon_pkg::NONE);
            press(gencon_pkg::DIGIT, 5, gencon_pkg::NONE);
            equal_and_check();

            // Fresh operands after a large result
            press(gencon_pkg::DIGIT, 9, gencon_pkg::NONE);
            press(gencon_pkg::DIGIT, 9, gencon_pkg::NONE);
            press(gencon_pkg::OPER, 0, gencon_pkg::MUL);
            press(gencon_pkg::DIGIT, 9, gencon_pkg::NONE);
            press(gencon_pkg::DIGIT, 9, gencon_pkg::NONE);
            equal_and_check();
            press(gencon_pkg::DIGIT, 7, gencon_pkg::NONE);
            press(gencon_pkg::OPER, 0, gencon_pkg::ADD);
            press(gencon_pkg::DIGIT, 5, gencon_pkg::NONE);
            equal_and_check();

            print_counts();
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

// ==== tests/tb_clock.sv ====
// 40 ns clock from time zero; nRST held low for 4 rising edges and released on a falling edge
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        nRST = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
    end

endmodule

// ==== hdl/calc_top.sv ====
// Keys come in as already debounced events; display holds the last result until the next one
`timescale 1ns/1ns
`include "gencon_cfg.svh"

module calc_top (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   key_valid,
    input  gencon_pkg::key_event_t key_in,
    output logic                   key_ready,
    output logic                   complete,
    output gencon_pkg::operand_t   display
);

    logic                   pending;
    logic                   key_read;
    gencon_pkg::key_event_t pending_key;

    key_buffer u_keys (
        .clk         (clk),
        .nRST        (nRST),
        .key_valid   (key_valid),
        .key_in      (key_in),
        .key_ready   (key_ready),
        .pending     (pending),
        .pending_key (pending_key),
        .key_read    (key_read)
    );

    gencon u_gencon (
        .clk         (clk),
        .nRST        (nRST),
        .pending     (pending),
        .pending_key (pending_key),
        .key_read    (key_read),
        .complete    (complete),
        .display     (display)
    );

endmodule

// ==== hdl/gencon.sv ====
// One operator per expression, no chaining; keys are consumed only in WAIT_OP1 and WAIT_OP2
`timescale 1ns/1ns
`include "gencon_cfg.svh"

module gencon (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   pending,
    input  gencon_pkg::key_event_t pending_key,
    output logic                   key_read,
    output logic                   complete,
    output gencon_pkg::operand_t   display
);

    localparam int MAG_W = `GENCON_WIDTH - 1;

    gencon_pkg::state_t   state;
    gencon_pkg::state_t   next_state;
    gencon_pkg::operand_t operand1;
    gencon_pkg::operand_t operand2;
    gencon_pkg::op_t      op_latched;
    logic [3:0]           digit_latched;

    logic                 consume;
    logic                 entry_op2;
    logic [MAG_W-1:0]     cur_mag;

    logic                 start_add;
    logic                 add_sub;
    logic                 add_finish;
    gencon_pkg::operand_t add_result;

    logic                 start_mult;
    gencon_pkg::operand_t mult_a;
    gencon_pkg::operand_t mult_b;
    logic                 mult_finish;
    gencon_pkg::operand_t mult_result;

    addsub_unit u_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_add),
        .a      (operand1),
        .b      (operand2),
        .sub    (add_sub),
        .result (add_result),
        .finish (add_finish)
    );

    shift_add_mult u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mult),
        .a      (mult_a),
        .b      (mult_b),
        .result (mult_result),
        .finish (mult_finish)
    );

    // key_read still high means the buffer has not dropped this key yet
    assign consume = pending && !key_read
                     && (state == gencon_pkg::WAIT_OP1 || state == gencon_pkg::WAIT_OP2);
    assign entry_op2 = (state == gencon_pkg::WAIT_OP2);
    assign cur_mag   = entry_op2 ? operand2.mag : operand1.mag;

    always_comb begin
        next_state = state;
        start_mult = 1'b0;
        start_add  = 1'b0;
        add_sub    = (op_latched == gencon_pkg::SUB);
        // Digit entry multiplies the magnitude by the base and keeps the sign here
        mult_a.sign = 1'b0;
        mult_a.mag  = cur_mag;
        mult_b.sign = 1'b0;
        mult_b.mag  = MAG_W'(`GENCON_BASE);

        case (state)
            gencon_pkg::WAIT_OP1, gencon_pkg::WAIT_OP2: begin
                if (consume) begin
                    case (pending_key.kind)
                        gencon_pkg::DIGIT: begin
                            start_mult = 1'b1;
                            next_state = entry_op2 ? gencon_pkg::WAIT_MULT_OP2
                                                   : gencon_pkg::WAIT_MULT_OP1;
                        end
                        gencon_pkg::OPER: begin
                            if (!entry_op2 && (pending_key.oper == gencon_pkg::ADD
                                    || pending_key.oper == gencon_pkg::SUB
                                    || pending_key.oper == gencon_pkg::MUL)) begin
                                next_state = gencon_pkg::WAIT_OP2;
                            end
                        end
                        gencon_pkg::EQUAL: begin
                            if (entry_op2) begin
                                next_state = gencon_pkg::SEND_TO_COMPUTE;
                            end
                        end
                        default: next_state = state;
                    endcase
                end
            end
            gencon_pkg::WAIT_MULT_OP1: begin
                if (mult_finish) begin
                    next_state = gencon_pkg::ADD_KEY_OP1;
                end
            end
            gencon_pkg::ADD_KEY_OP1: next_state = gencon_pkg::WAIT_OP1;
            gencon_pkg::WAIT_MULT_OP2: begin
                if (mult_finish) begin
                    next_state = gencon_pkg::ADD_KEY_OP2;
                end
            end
            gencon_pkg::ADD_KEY_OP2: next_state = gencon_pkg::WAIT_OP2;
            gencon_pkg::SEND_TO_COMPUTE: begin
                if (op_latched == gencon_pkg::MUL) begin
                    start_mult = 1'b1;
                    mult_a     = operand1;
                    mult_b     = operand2;
                end else begin
                    start_add = 1'b1;
                end
                next_state = gencon_pkg::WAIT_COMPUTE;
            end
            gencon_pkg::WAIT_COMPUTE: begin
                if (op_latched == gencon_pkg::MUL ? mult_finish : add_finish) begin
                    next_state = gencon_pkg::SHOW_RESULT;
                end
            end
            gencon_pkg::SHOW_RESULT: next_state = gencon_pkg::WAIT_OP1;
            default: next_state = gencon_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= gencon_pkg::WAIT_OP1;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_read      <= 1'b0;
            complete      <= 1'b0;
            display       <= '0;
            operand1      <= '0;
            operand2      <= '0;
            op_latched    <= gencon_pkg::NONE;
            digit_latched <= '0;
        end else begin
            key_read <= consume;
            complete <= (state == gencon_pkg::SHOW_RESULT);

            if (consume && pending_key.kind == gencon_pkg::DIGIT) begin
                digit_latched <= pending_key.digit;
            end
            if (consume && pending_key.kind == gencon_pkg::OPER) begin
                if (pending_key.oper == gencon_pkg::NEG) begin
                    if (entry_op2) begin
                        operand2.sign <= ~operand2.sign;
                    end else begin
                        operand1.sign <= ~operand1.sign;
                    end
                end else if (!entry_op2 && pending_key.oper != gencon_pkg::NONE) begin
                    op_latched <= pending_key.oper;
                end
            end

            case (state)
                gencon_pkg::ADD_KEY_OP1: operand1.mag <= mult_result.mag + MAG_W'(digit_latched);
                gencon_pkg::ADD_KEY_OP2: operand2.mag <= mult_result.mag + MAG_W'(digit_latched);
                gencon_pkg::SHOW_RESULT: begin
                    display    <= (op_latched == gencon_pkg::MUL) ? mult_result : add_result;
                    operand1   <= '0;
                    operand2   <= '0;
                    op_latched <= gencon_pkg::NONE;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hdl/shift_add_mult.sv ====
// Product magnitude is truncated to 15 bits; start is ignored while a multiply is in progress
`timescale 1ns/1ns
`include "gencon_cfg.svh"

module shift_add_mult (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 start,
    input  gencon_pkg::operand_t a,
    input  gencon_pkg::operand_t b,
    output gencon_pkg::operand_t result,
    output logic                 finish
);

    localparam int MAG_W = `GENCON_WIDTH - 1;
    localparam int CNT_W = $clog2(MAG_W + 1);

    logic             busy;
    logic             load;
    logic             step;
    logic [CNT_W-1:0] steps_left;
    logic [MAG_W-1:0] mcand;
    logic [MAG_W-1:0] mplier;
    logic [MAG_W-1:0] acc;
    logic             prod_sign;

    assign load = start && !busy;
    assign step = busy && (steps_left != '0);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            steps_left <= '0;
            finish     <= 1'b0;
            result     <= '0;
        end else begin
            finish <= 1'b0;
            if (load) begin
                busy       <= 1'b1;
                steps_left <= CNT_W'(MAG_W);
            end else if (step) begin
                steps_left <= steps_left - 1'b1;
            end else if (busy) begin
                // All multiplier bits consumed
                busy        <= 1'b0;
                finish      <= 1'b1;
                result.mag  <= acc;
                result.sign <= prod_sign && (acc != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mcand     <= a.mag;
            mplier    <= b.mag;
            acc       <= '0;
            prod_sign <= a.sign ^ b.sign;
        end else if (step) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

// ==== hdl/addsub_unit.sv ====
// Registered add/subtract with finish one edge after start is sampled; magnitude wraps modulo 2^15 with no overflow flag
`timescale 1ns/1ns
`include "gencon_cfg.svh"

module addsub_unit (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 start,
    input  gencon_pkg::operand_t a,
    input  gencon_pkg::operand_t b,
    input  logic                 sub,
    output gencon_pkg::operand_t result,
    output logic                 finish
);

    logic                 b_sign;
    logic                 sum_valid;
    gencon_pkg::operand_t sum;
    gencon_pkg::operand_t sum_q;

    always_comb begin
        // Subtraction is addition of the negated b
        b_sign = b.sign ^ sub;
        sum    = '0;
        if (a.sign == b_sign) begin
            sum.mag  = a.mag + b.mag;
            sum.sign = a.sign;
        end else if (a.mag >= b.mag) begin
            sum.mag  = a.mag - b.mag;
            sum.sign = a.sign;
        end else begin
            sum.mag  = b.mag - a.mag;
            sum.sign = b_sign;
        end
        // No negative zero
        if (sum.mag == '0) begin
            sum.sign = 1'b0;
        end
    end

    // Sum captured on start and handed out one edge later
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            sum_q     <= '0;
            sum_valid <= 1'b0;
            result    <= '0;
            finish    <= 1'b0;
        end else begin
            sum_valid <= start;
            finish    <= sum_valid;
            if (start) begin
                sum_q <= sum;
            end
            if (sum_valid) begin
                result <= sum_q;
            end
        end
    end

endmodule

// ==== hdl/key_buffer.sv ====
// Holds a single key; key_ready drops while a key is pending and the sender must hold its key
`timescale 1ns/1ns
`include "gencon_cfg.svh"

module key_buffer (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   key_valid,
    input  gencon_pkg::key_event_t key_in,
    output logic                   key_ready,
    output logic                   pending,
    output gencon_pkg::key_event_t pending_key,
    input  logic                   key_read
);

    logic                   full;
    logic                   accept;
    gencon_pkg::key_event_t held_key;

    // Only take a key into an empty entry
    assign accept = key_valid && !full;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            full <= 1'b0;
        end else if (key_read) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_key <= key_in;
        end
    end

    assign key_ready   = !full;
    assign pending     = full;
    assign pending_key = held_key;

endmodule

// ==== hdl/gencon_pkg.sv ====
// Operands are sign-magnitude with a 15-bit magnitude; op_t codes match the keypad encoder
`include "gencon_cfg.svh"

package gencon_pkg;

    // Operator codes as sent by the keypad
    typedef enum logic [2:0] {
        NONE = 3'd0,
        NEG  = 3'd1,
        ADD  = 3'd2,
        SUB  = 3'd3,
        MUL  = 3'd4
    } op_t;

    typedef enum logic [1:0] {
        DIGIT = 2'd0,
        OPER  = 2'd1,
        EQUAL = 2'd2
    } key_kind_t;

    // One key press
    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] digit;
        op_t        oper;
    } key_event_t;

    typedef struct packed {
        logic                       sign;
        logic [`GENCON_WIDTH-2:0]   mag;
    } operand_t;

    // Sequencer states
    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT
    } state_t;

endpackage

// ==== hdl/gencon_cfg.svh ====
// Data width includes the sign bit; only base 10 digit entry with 4-bit digit codes is supported
`ifndef GENCON_CFG_SVH
`define GENCON_CFG_SVH

// Operand and result width, sign bit on top
`define GENCON_WIDTH 16

// Base of digit entry
// Digit codes are 4 bits wide, so the base must stay at or below 16
`define GENCON_BASE 10

`endif
